// ==== filelist.f ====
common/dcache_pkg.sv
data_array/data_memory_bank.sv
data_array/data_way.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/dcache_data_array.sv
verif/tb_dcache_data_array.sv

// ==== Bender.yml ====
package:
  name: dcache_data_array

sources:
  - common/dcache_pkg.sv
  - data_array/data_memory_bank.sv
  - data_array/data_way.sv
  - rtl/store_align.sv
  - rtl/load_align.sv
  - rtl/dcache_data_array.sv
  - target: test
    files:
      - verif/tb_dcache_data_array.sv

// ==== verif/tb_dcache_data_array.sv ====
/*
 * Random testbench for the data cache data array.
 * A word model per way, set and word is updated at the same edge as the DUT.
 * Loads are predicted from the model before that edge's write and checked
 * one cycle later. Only aligned accesses and legal widths are generated.
 */

`timescale 1ns/100ps

module tb_dcache_data_array;

    // Refill of all sets, then the random run, then two idle cycles to drain
    localparam int REFILL_CYCLES = dcache_pkg::WAYS * dcache_pkg::SETS;
    localparam int RANDOM_CYCLES = 2000;
    localparam int RUN_CYCLES    = REFILL_CYCLES + RANDOM_CYCLES + 2;
    // About 2140 cycles with reset, so 3000 leaves a wide margin
    localparam int TIMEOUT_CYCLES = 3000;

    logic                  clk_i;
    logic                  rst_i;
    logic                  refill_i;
    dcache_pkg::way_t      refill_way_i;
    dcache_pkg::index_t    refill_index_i;
    dcache_pkg::block_t    refill_block_i;
    logic                  store_i;
    dcache_pkg::way_t      store_way_i;
    dcache_pkg::index_t    store_index_i;
    dcache_pkg::word_sel_t store_word_i;
    dcache_pkg::byte_ofs_t store_offset_i;
    dcache_pkg::width_t    store_width_i;
    dcache_pkg::word_t     store_data_i;
    logic                  load_i;
    dcache_pkg::way_t      load_way_i;
    dcache_pkg::index_t    load_index_i;
    dcache_pkg::word_sel_t load_word_i;
    dcache_pkg::byte_ofs_t load_offset_i;
    dcache_pkg::width_t    load_width_i;
    logic                  load_unsigned_i;
    dcache_pkg::word_t     load_data_o;
    logic                  load_valid_o;

    // Reference contents of the whole array
    dcache_pkg::word_t model [dcache_pkg::WAYS][dcache_pkg::SETS][dcache_pkg::BLOCK_WORDS];

    // Prediction for the load sampled at the last rising edge
    logic              exp_valid;
    dcache_pkg::word_t exp_data;

    int checks;
    int valid_errors;
    int data_errors;
    int cycles;

    dcache_data_array dcache_data_array_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------
    // Reference rules
    // ------------------------------

    // Offset that is legal for the given width
    function automatic dcache_pkg::byte_ofs_t aligned_offset(dcache_pkg::width_t width);
        if (width == dcache_pkg::WIDTH_BYTE) begin
            return dcache_pkg::byte_ofs_t'($urandom_range(3));
        end
        if (width == dcache_pkg::WIDTH_HALF) begin
            return dcache_pkg::byte_ofs_t'($urandom_range(1) * 2);
        end
        return '0;
    endfunction

    // Low store bytes land at the offset, everything else keeps its old value
    function automatic dcache_pkg::word_t merge_store(dcache_pkg::word_t old,
            dcache_pkg::byte_ofs_t ofs, dcache_pkg::width_t width, dcache_pkg::word_t data);
        dcache_pkg::word_t res;
        int                nbytes;
        res    = old;
        nbytes = (width == dcache_pkg::WIDTH_BYTE) ? 1 : (width == dcache_pkg::WIDTH_HALF) ? 2 : 4;
        for (int k = 0; k < nbytes; k++) begin
            res[(int'(ofs) + k) * 8 +: 8] = data[k * 8 +: 8];
        end
        return res;
    endfunction

    // RISC-V LB/LBU/LH/LHU/LW result for one stored word
    function automatic dcache_pkg::word_t expected_load(dcache_pkg::word_t w,
            dcache_pkg::byte_ofs_t ofs, dcache_pkg::width_t width, logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[int'(ofs) * 8 +: 8];
        h = w[int'(ofs) * 8 +: 16];
        if (width == dcache_pkg::WIDTH_BYTE) begin
            return uns ? {24'h0, b} : {{24{b[7]}}, b};
        end
        if (width == dcache_pkg::WIDTH_HALF) begin
            return uns ? {16'h0, h} : {{16{h[15]}}, h};
        end
        return w;
    endfunction

    // ------------------------------
    // Model update and checks
    // ------------------------------

    // Called at the rising edge, so the inputs read here are the sampled ones
    task automatic track_model();
        exp_valid = load_i;
        if (load_i) begin
            // Read before write, as the banks do
            exp_data = expected_load(model[load_way_i][load_index_i][load_word_i],
                                     load_offset_i, load_width_i, load_unsigned_i);
        end
        if (refill_i) begin
            for (int b = 0; b < dcache_pkg::BLOCK_WORDS; b++) begin
                model[refill_way_i][refill_index_i][b] = refill_block_i[b * 32 +: 32];
            end
        end
        if (store_i) begin
            model[store_way_i][store_index_i][store_word_i] =
                merge_store(model[store_way_i][store_index_i][store_word_i],
                            store_offset_i, store_width_i, store_data_i);
        end
    endtask

    task automatic check_outputs();
        checks++;
        if (load_valid_o !== exp_valid) begin
            valid_errors++;
            $display("error: load_valid_o got %h expected %h", load_valid_o, exp_valid);
        end
        if (exp_valid && load_data_o !== exp_data) begin
            data_errors++;
            $display("error: load_data_o got %h expected %h", load_data_o, exp_data);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic drive_cycle(int n);
        int                 r;
        dcache_pkg::width_t sw;
        dcache_pkg::width_t lw;
        r  = $urandom_range(99);
        sw = dcache_pkg::width_t'($urandom_range(2));
        lw = dcache_pkg::width_t'($urandom_range(2));
        refill_block_i  <= {$urandom, $urandom, $urandom, $urandom};
        store_way_i     <= dcache_pkg::way_t'($urandom_range(1));
        store_index_i   <= dcache_pkg::index_t'($urandom_range(3));
        store_word_i    <= dcache_pkg::word_sel_t'($urandom_range(3));
        store_width_i   <= sw;
        store_offset_i  <= aligned_offset(sw);
        store_data_i    <= $urandom;
        load_way_i      <= dcache_pkg::way_t'($urandom_range(1));
        load_index_i    <= dcache_pkg::index_t'($urandom_range(3));
        load_word_i     <= dcache_pkg::word_sel_t'($urandom_range(3));
        load_width_i    <= lw;
        load_offset_i   <= aligned_offset(lw);
        load_unsigned_i <= 1'($urandom_range(1));
        if (n < REFILL_CYCLES) begin
            // Fill way n / SETS, set n % SETS
            refill_i       <= 1'b1;
            refill_way_i   <= dcache_pkg::way_t'(n / dcache_pkg::SETS);
            refill_index_i <= dcache_pkg::index_t'(n % dcache_pkg::SETS);
            store_i        <= 1'b0;
            load_i         <= 1'b0;
        end else if (n < REFILL_CYCLES + RANDOM_CYCLES) begin
            // Refill 5 %, store 40 %, load independent at 50 %
            refill_i       <= (r < 5);
            refill_way_i   <= dcache_pkg::way_t'($urandom_range(1));
            refill_index_i <= dcache_pkg::index_t'($urandom_range(3));
            store_i        <= (r >= 5 && r < 45);
            load_i         <= ($urandom_range(1) == 0);
        end else begin
            refill_i <= 1'b0;
            store_i  <= 1'b0;
            load_i   <= 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h8b25));
        rst_i           = 1'b1;
        refill_i        = 1'b0;
        refill_way_i    = '0;
        refill_index_i  = '0;
        refill_block_i  = '0;
        store_i         = 1'b0;
        store_way_i     = '0;
        store_index_i   = '0;
        store_word_i    = '0;
        store_offset_i  = '0;
        store_width_i   = dcache_pkg::WIDTH_WORD;
        store_data_i    = '0;
        load_i          = 1'b0;
        load_way_i      = '0;
        load_index_i    = '0;
        load_word_i     = '0;
        load_offset_i   = '0;
        load_width_i    = dcache_pkg::WIDTH_WORD;
        load_unsigned_i = 1'b0;
        checks          = 0;
        valid_errors    = 0;
        data_errors     = 0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int n = 0; n < RUN_CYCLES; n++) begin
            @(posedge clk_i);
            track_model();
            drive_cycle(n);
            // Outputs are settled half a period after the edge
            @(negedge clk_i);
            check_outputs();
        end
        $display("checks %0d, valid errors %0d, data errors %0d",
                 checks, valid_errors, data_errors);
        if (valid_errors == 0 && data_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog on the cycle count
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== rtl/dcache_data_array.sv ====
/*
 * Data storage of a two-way set-associative data cache.
 * The caller supplies the hitting way, tags and replacement live elsewhere.
 * Refill and store must not be requested in the same cycle.
 * Load results appear one cycle after load_i, with load_valid_o.
 */

`timescale 1ns/100ps

module dcache_data_array (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Refill
    input  logic                  refill_i,
    input  dcache_pkg::way_t      refill_way_i,
    input  dcache_pkg::index_t    refill_index_i,
    input  dcache_pkg::block_t    refill_block_i,

    // Store
    input  logic                  store_i,
    input  dcache_pkg::way_t      store_way_i,
    input  dcache_pkg::index_t    store_index_i,
    input  dcache_pkg::word_sel_t store_word_i,
    input  dcache_pkg::byte_ofs_t store_offset_i,
    input  dcache_pkg::width_t    store_width_i,
    input  dcache_pkg::word_t     store_data_i,

    // Load
    input  logic                  load_i,
    input  dcache_pkg::way_t      load_way_i,
    input  dcache_pkg::index_t    load_index_i,
    input  dcache_pkg::word_sel_t load_word_i,
    input  dcache_pkg::byte_ofs_t load_offset_i,
    input  dcache_pkg::width_t    load_width_i,
    input  logic                  load_unsigned_i,
    output dcache_pkg::word_t     load_data_o,
    output logic                  load_valid_o
);

    // Lane-aligned store data, shared by both ways
    dcache_pkg::strb_t st_strb;
    dcache_pkg::word_t st_data;

    // Read word of each way
    dcache_pkg::word_t [dcache_pkg::WAYS-1:0] rd_word;

    store_align store_align_i (
        .clk_i          (clk_i),
        .store_i        (store_i),
        .store_offset_i (store_offset_i),
        .store_width_i  (store_width_i),
        .store_data_i   (store_data_i),
        .st_strb_o      (st_strb),
        .st_data_o      (st_data)
    );

    // ------------------------------
    // Ways
    // ------------------------------

    for (genvar w = 0; w < dcache_pkg::WAYS; w++) begin : g_way
        data_way #(
            .WAY_INDEX (w)
        ) data_way_i (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .refill_i       (refill_i),
            .refill_way_i   (refill_way_i),
            .refill_index_i (refill_index_i),
            .refill_block_i (refill_block_i),
            .store_i        (store_i),
            .store_way_i    (store_way_i),
            .store_index_i  (store_index_i),
            .store_word_i   (store_word_i),
            .st_strb_i      (st_strb),
            .st_data_i      (st_data),
            .load_i         (load_i),
            .load_way_i     (load_way_i),
            .load_index_i   (load_index_i),
            .load_word_i    (load_word_i),
            .rd_word_o      (rd_word[w])
        );
    end

    load_align load_align_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .load_i          (load_i),
        .load_way_i      (load_way_i),
        .load_offset_i   (load_offset_i),
        .load_width_i    (load_width_i),
        .load_unsigned_i (load_unsigned_i),
        .way_word_i      (rd_word),
        .load_data_o     (load_data_o),
        .load_valid_o    (load_valid_o)
    );

endmodule

// ==== rtl/load_align.sv ====
/*
 * Load aligner with a fixed latency of one clock.
 * load_data_o is combinational from the registered bank words and the
 * registered load attributes. It is meaningful only while load_valid_o
 * is high. Misaligned loads are only reported by an assertion.
 */

`timescale 1ns/100ps

module load_align (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      load_i,
    input  dcache_pkg::way_t                          load_way_i,
    input  dcache_pkg::byte_ofs_t                     load_offset_i,
    input  dcache_pkg::width_t                        load_width_i,
    input  logic                                      load_unsigned_i,
    input  dcache_pkg::word_t [dcache_pkg::WAYS-1:0]  way_word_i,
    output dcache_pkg::word_t                         load_data_o,
    output logic                                      load_valid_o
);

    // Attributes of the load in flight
    dcache_pkg::way_t      way_q;
    dcache_pkg::byte_ofs_t offset_q;
    dcache_pkg::width_t    width_q;
    logic                  unsigned_q;
    logic                  valid_q;

    // Selected word with the addressed bytes moved to lane 0
    dcache_pkg::word_t shifted;

    // ------------------------------
    // Request registers
    // ------------------------------

    // Attributes load only with a request, so the result holds between loads
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            way_q      <= load_way_i;
            offset_q   <= load_offset_i;
            width_q    <= load_width_i;
            unsigned_q <= load_unsigned_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_i;
        end
    end

    assign load_valid_o = valid_q;

    // ------------------------------
    // Extraction and extension
    // ------------------------------

    assign shifted = way_word_i[way_q] >> {offset_q, 3'b000};

    always_comb begin
        case (width_q)
            dcache_pkg::WIDTH_BYTE: begin
                load_data_o = {{24{!unsigned_q && shifted[7]}}, shifted[7:0]};
            end
            dcache_pkg::WIDTH_HALF: begin
                load_data_o = {{16{!unsigned_q && shifted[15]}}, shifted[15:0]};
            end
            default: begin
                // Word loads need no extension
                load_data_o = shifted;
            end
        endcase
    end

    // Same alignment rule as for stores
    assert property (@(posedge clk_i) disable iff (rst_i) load_i |->
        (load_width_i == dcache_pkg::WIDTH_BYTE) ||
        (load_width_i == dcache_pkg::WIDTH_HALF && !load_offset_i[0]) ||
        (load_width_i == dcache_pkg::WIDTH_WORD && load_offset_i == '0))
        else $error("misaligned load or illegal width %0d", load_width_i);

endmodule

// ==== rtl/store_align.sv ====
/*
 * Store aligner for RISC-V byte, half-word and word stores.
 * The offset must be aligned to the width, misaligned stores are only
 * reported by an assertion. Width code 3 produces no strobes.
 */

`timescale 1ns/100ps

module store_align (
    input  logic                  clk_i,
    input  logic                  store_i,
    input  dcache_pkg::byte_ofs_t store_offset_i,
    input  dcache_pkg::width_t    store_width_i,
    input  dcache_pkg::word_t     store_data_i,
    output dcache_pkg::strb_t     st_strb_o,
    output dcache_pkg::word_t     st_data_o
);

    // ------------------------------
    // Strobes and lane replication
    // ------------------------------

    always_comb begin
        case (store_width_i)
            dcache_pkg::WIDTH_BYTE: begin
                // One lane, the low byte is copied to every lane
                st_strb_o = dcache_pkg::strb_t'(4'b0001) << store_offset_i;
                st_data_o = {4{store_data_i[7:0]}};
            end
            dcache_pkg::WIDTH_HALF: begin
                // Two lanes at offset 0 or 2, low half copied to both halves
                st_strb_o = dcache_pkg::strb_t'(4'b0011) << store_offset_i;
                st_data_o = {2{store_data_i[15:0]}};
            end
            dcache_pkg::WIDTH_WORD: begin
                st_strb_o = '1;
                st_data_o = store_data_i;
            end
            default: begin
                // Illegal width, nothing is written
                st_strb_o = '0;
                st_data_o = store_data_i;
            end
        endcase
    end

    // ------------------------------
    // Alignment check
    // ------------------------------

    // Half-words need an even offset, words offset zero, code 3 is illegal
    assert property (@(posedge clk_i) store_i |->
        (store_width_i == dcache_pkg::WIDTH_BYTE) ||
        (store_width_i == dcache_pkg::WIDTH_HALF && !store_offset_i[0]) ||
        (store_width_i == dcache_pkg::WIDTH_WORD && store_offset_i == '0))
        else $error("misaligned store or illegal width %0d", store_width_i);

endmodule

// ==== data_array/data_way.sv ====
/*
 * One cache way, built from one bank per block word.
 * The caller must never raise refill_i and store_i in the same cycle.
 * rd_word_o is the word of the last load to this way and holds until
 * the next load to this way.
 */

`timescale 1ns/100ps

module data_way #(
    parameter int WAY_INDEX = 0
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Block refill from the miss path
    input  logic                  refill_i,
    input  dcache_pkg::way_t      refill_way_i,
    input  dcache_pkg::index_t    refill_index_i,
    input  dcache_pkg::block_t    refill_block_i,

    // Aligned store
    input  logic                  store_i,
    input  dcache_pkg::way_t      store_way_i,
    input  dcache_pkg::index_t    store_index_i,
    input  dcache_pkg::word_sel_t store_word_i,
    input  dcache_pkg::strb_t     st_strb_i,
    input  dcache_pkg::word_t     st_data_i,

    // Load request
    input  logic                  load_i,
    input  dcache_pkg::way_t      load_way_i,
    input  dcache_pkg::index_t    load_index_i,
    input  dcache_pkg::word_sel_t load_word_i,
    output dcache_pkg::word_t     rd_word_o
);

    // Requests that address this way
    logic refill_hit;
    logic store_hit;
    logic load_hit;

    // Registered outputs of all banks
    dcache_pkg::word_t bank_data [dcache_pkg::BLOCK_WORDS];

    // Bank picked by the last load to this way
    dcache_pkg::word_sel_t word_sel_q;

    assign refill_hit = refill_i && (refill_way_i == dcache_pkg::way_t'(WAY_INDEX));
    assign store_hit  = store_i && (store_way_i == dcache_pkg::way_t'(WAY_INDEX));
    assign load_hit   = load_i && (load_way_i == dcache_pkg::way_t'(WAY_INDEX));

    // ------------------------------
    // Banks
    // ------------------------------

    for (genvar b = 0; b < dcache_pkg::BLOCK_WORDS; b++) begin : g_bank
        logic               wr;
        logic               rd;
        dcache_pkg::strb_t  wr_strb;
        dcache_pkg::index_t wr_index;
        dcache_pkg::word_t  wr_data;

        // A refill writes every bank with its own slice, a store only its word
        assign wr       = refill_hit || (store_hit && store_word_i == dcache_pkg::word_sel_t'(b));
        assign wr_strb  = refill_hit ? '1 : st_strb_i;
        assign wr_index = refill_hit ? refill_index_i : store_index_i;
        assign wr_data  = refill_hit ? refill_block_i[b*$bits(dcache_pkg::word_t) +:
                                                      $bits(dcache_pkg::word_t)]
                                     : st_data_i;

        // Only the addressed bank reads, so the others keep their old word
        assign rd = load_hit && (load_word_i == dcache_pkg::word_sel_t'(b));

        data_memory_bank bank_i (
            .clk_i      (clk_i),
            .wr_i       (wr),
            .wr_strb_i  (wr_strb),
            .wr_index_i (wr_index),
            .wr_data_i  (wr_data),
            .rd_i       (rd),
            .rd_index_i (load_index_i),
            .rd_data_o  (bank_data[b])
        );
    end

    // ------------------------------
    // Read word select
    // ------------------------------

    // The select follows the bank output by one cycle, as the read is registered
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            word_sel_q <= '0;
        end else if (load_hit) begin
            word_sel_q <= load_word_i;
        end
    end

    assign rd_word_o = bank_data[word_sel_q];

    // Refill and store share the bank write ports, so they must never collide
    assert property (@(posedge clk_i) disable iff (rst_i) !(refill_i && store_i))
        else $error("refill_i and store_i high in the same cycle");

endmodule

// ==== data_array/data_memory_bank.sv ====
/*
 * One word-wide bank of a cache way, SETS words deep.
 * The write port updates only the strobed bytes.
 * The read port is registered and holds its output while rd_i is low.
 * A read and a write to the same word return the old contents.
 */

`timescale 1ns/100ps

module data_memory_bank (
    input  logic               clk_i,

    // Write port
    input  logic               wr_i,
    input  dcache_pkg::strb_t  wr_strb_i,
    input  dcache_pkg::index_t wr_index_i,
    input  dcache_pkg::word_t  wr_data_i,

    // Read port
    input  logic               rd_i,
    input  dcache_pkg::index_t rd_index_i,
    output dcache_pkg::word_t  rd_data_o
);

    // Storage array, one word per set
    dcache_pkg::word_t mem [dcache_pkg::SETS];

    // ------------------------------
    // Byte-strobed write
    // ------------------------------

    always_ff @(posedge clk_i) begin : write_port
        if (wr_i) begin
            for (int i = 0; i < dcache_pkg::WORD_BYTES; i++) begin
                // Only lanes with their strobe set are touched
                if (wr_strb_i[i]) begin
                    mem[wr_index_i][i*8 +: 8] <= wr_data_i[i*8 +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Registered read
    // ------------------------------

    // The output register keeps the last word read until the next enabled read
    always_ff @(posedge clk_i) begin : read_port
        if (rd_i) begin
            rd_data_o <= mem[rd_index_i];
        end
    end

endmodule

// ==== common/dcache_pkg.sv ====
/*
 * Shared geometry, width types and access-width codes of the data cache
 * data array. Two ways of 64 sets, four 32-bit words per block.
 * Changing the geometry here resizes every block that uses these types.
 * Width code 3 is not a legal access width.
 */

package dcache_pkg;

    // ------------------------------
    // Geometry
    // ------------------------------

    // Number of ways in each set
    localparam int WAYS = 2;

    // Words per cache block, one memory bank for each word
    localparam int BLOCK_WORDS = 4;

    // Number of sets, which is also the depth of each bank
    localparam int SETS = 64;

    // Bytes per data word
    localparam int WORD_BYTES = 4;

    // ------------------------------
    // Width types
    // ------------------------------

    typedef logic [WORD_BYTES*8-1:0]             word_t;
    typedef logic [WORD_BYTES-1:0]               strb_t;
    // Word 0 of the block sits in the lowest bits
    typedef logic [BLOCK_WORDS*WORD_BYTES*8-1:0] block_t;
    typedef logic [$clog2(SETS)-1:0]             index_t;
    typedef logic [$clog2(BLOCK_WORDS)-1:0]      word_sel_t;
    typedef logic [$clog2(WORD_BYTES)-1:0]       byte_ofs_t;
    typedef logic [$clog2(WAYS)-1:0]             way_t;
    typedef logic [1:0]                          width_t;

    // ------------------------------
    // Access-width codes
    // ------------------------------

    localparam width_t WIDTH_BYTE = 2'd0;
    localparam width_t WIDTH_HALF = 2'd1;
    localparam width_t WIDTH_WORD = 2'd2;

endpackage
